//--- rtl/accelerator_trainer.sv
// Top of the gradient stage: FSM, shared index counter, step datapath and
// the dW, dK, dU and db banks; host pushes d, x, r, h per step after START

`timescale 1ns/1ps

module accelerator_trainer
  import ntm_dims_pkg::*;
  import trainer_ctrl_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              START,
  output logic              READY,
  input  logic [SIZE_W-1:0] SIZE_T_IN,
  input  logic [SIZE_W-1:0] SIZE_L_IN,
  input  logic [SIZE_W-1:0] SIZE_X_IN,
  input  logic [SIZE_W-1:0] SIZE_R_IN,
  input  data_t             D_IN,
  input  logic              D_IN_ENABLE,
  input  data_t             X_IN,
  input  logic              X_IN_ENABLE,
  input  data_t             R_IN,
  input  logic              R_IN_ENABLE,
  input  data_t             H_IN,
  input  logic              H_IN_ENABLE,
  output acc_t              W_OUT,
  output logic              W_OUT_L_ENABLE,
  output logic              W_OUT_X_ENABLE,
  output acc_t              K_OUT,
  output logic              K_OUT_L_ENABLE,
  output logic              K_OUT_K_ENABLE,
  output acc_t              U_OUT,
  output logic              U_OUT_L_ENABLE,
  output logic              U_OUT_P_ENABLE,
  output bias_t             B_OUT,
  output logic              B_OUT_ENABLE
);

  // Counter
  logic              cnt_clear, cnt_advance, first_col, last;
  logic [SIZE_W-1:0] row_limit, col_limit;
  logic [IDX_W-1:0]  row, col;
  // Datapath control and terms
  ldsel_t            load_sel;
  opsel_t            opsel;
  logic              load_we, mul_en, shift_h, term_valid;
  prod_t             term;
  logic [IDX_W-1:0]  term_row, term_col;
  // Bank control
  logic              bank_clear;
  logic [3:0]        acc_sel, rd_en;
  logic [IDX_W-1:0]  rd_row, rd_col;

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  trainer_fsm u_fsm (
    .CLK, .RST, .START, .SIZE_T_IN, .SIZE_L_IN, .SIZE_X_IN, .SIZE_R_IN,
    .D_IN_ENABLE, .X_IN_ENABLE, .R_IN_ENABLE, .H_IN_ENABLE,
    .row, .col, .first_col, .last,
    .cnt_clear, .cnt_advance, .row_limit, .col_limit,
    .load_sel, .load_we, .opsel, .mul_en, .shift_h,
    .bank_clear, .acc_sel, .rd_en, .rd_row, .rd_col,
    .W_OUT_L_ENABLE, .W_OUT_X_ENABLE, .K_OUT_L_ENABLE, .K_OUT_K_ENABLE,
    .U_OUT_L_ENABLE, .U_OUT_P_ENABLE, .B_OUT_ENABLE, .READY
  );

  index_counter u_counter (
    .CLK, .RST, .cnt_clear, .cnt_advance, .row_limit, .col_limit,
    .row, .col, .first_col, .last
  );

  step_datapath u_datapath (
    .CLK, .RST, .D_IN, .X_IN, .R_IN, .H_IN,
    .load_sel, .load_we, .opsel, .mul_en, .shift_h, .row, .col,
    .term, .term_row, .term_col, .term_valid
  );

  //////////////////////////////////////////////////////////////////////
  // Gradient banks
  //////////////////////////////////////////////////////////////////////

  gradient_bank #(.pay_t(acc_t), .ROWS(MAX_L), .COLS(MAX_COL)) w_bank (
    .CLK, .RST, .bank_clear, .acc_en(acc_sel[0] & term_valid),
    .term_row, .term_col, .term,
    .rd_en(rd_en[0]), .rd_row, .rd_col, .rd_data(W_OUT)
  );

  gradient_bank #(.pay_t(acc_t), .ROWS(MAX_L), .COLS(MAX_COL)) k_bank (
    .CLK, .RST, .bank_clear, .acc_en(acc_sel[1] & term_valid),
    .term_row, .term_col, .term,
    .rd_en(rd_en[1]), .rd_row, .rd_col, .rd_data(K_OUT)
  );

  gradient_bank #(.pay_t(acc_t), .ROWS(MAX_L), .COLS(MAX_COL)) u_bank (
    .CLK, .RST, .bank_clear, .acc_en(acc_sel[2] & term_valid),
    .term_row, .term_col, .term,
    .rd_en(rd_en[2]), .rd_row, .rd_col, .rd_data(U_OUT)
  );

  // One column, indexed by row
  gradient_bank #(.pay_t(bias_t), .ROWS(MAX_L), .COLS(1)) b_bank (
    .CLK, .RST, .bank_clear, .acc_en(acc_sel[3] & term_valid),
    .term_row, .term_col, .term,
    .rd_en(rd_en[3]), .rd_row, .rd_col, .rd_data(B_OUT)
  );

endmodule

//--- rtl/gradient_bank.sv
// Gradient accumulator memory, one per gradient matrix or vector
// Cleared at the start of a pass, adds one term per cycle, read registered

`timescale 1ns/1ps

module gradient_bank
  import ntm_dims_pkg::*;
#(
  parameter type pay_t = acc_t,
  parameter int  ROWS  = MAX_L,
  parameter int  COLS  = MAX_COL    // Row stride
) (
  input  logic             CLK,
  input  logic             RST,
  input  logic             bank_clear,
  input  logic             acc_en,
  input  logic [IDX_W-1:0] term_row,
  input  logic [IDX_W-1:0] term_col,
  input  prod_t            term,
  input  logic             rd_en,
  input  logic [IDX_W-1:0] rd_row,
  input  logic [IDX_W-1:0] rd_col,
  output pay_t             rd_data
);

  localparam int DEPTH = ROWS * COLS;
  localparam int AW    = $clog2(DEPTH);

  pay_t          mem [DEPTH];
  logic [AW-1:0] wr_addr;
  logic [AW-1:0] rd_addr;

  // Flat row-major addresses
  assign wr_addr = AW'(int'(term_row) * COLS + int'(term_col));
  assign rd_addr = AW'(int'(rd_row) * COLS + int'(rd_col));

  always_ff @(posedge CLK) begin
    if (bank_clear) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (acc_en) begin
      mem[wr_addr] <= mem[wr_addr] + pay_t'(term);  // Sign-extending add
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- rtl/index_counter.sv
// Row/column walker shared by all phases of a pass
// Loads run it with row_limit of 1, updates and outputs walk a full matrix

`timescale 1ns/1ps

module index_counter
  import ntm_dims_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              cnt_clear,    // Wins over advance
  input  logic              cnt_advance,
  input  logic [SIZE_W-1:0] row_limit,
  input  logic [SIZE_W-1:0] col_limit,
  output logic [IDX_W-1:0]  row,
  output logic [IDX_W-1:0]  col,
  output logic              first_col,
  output logic              last          // Final index of the walk
);

  logic row_end;
  logic col_end;

  assign col_end   = (SIZE_W'(col) == col_limit - SIZE_W'(1));
  assign row_end   = (SIZE_W'(row) == row_limit - SIZE_W'(1));
  assign first_col = (col == '0);
  assign last      = row_end & col_end;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      row <= '0;
      col <= '0;
    end else if (cnt_clear) begin
      row <= '0;
      col <= '0;
    end else if (cnt_advance) begin
      if (col_end) begin
        col <= '0;
        row <= row_end ? '0 : row + 1'b1;  // Wraps to 0 for the next phase
      end else begin
        col <= col + 1'b1;
      end
    end
  end

endmodule

//--- rtl/ntm_dims_pkg.sv
// Word widths, size maxima and signed payload types of the gradient stage
// Imported by every RTL block of the trainer

package ntm_dims_pkg;

  // Word widths
  localparam int DATA_W = 16;          // Streamed input words
  localparam int PROD_W = 2 * DATA_W;  // Full d*x product
  localparam int ACC_W  = 40;          // Matrix gradient sums
  localparam int BIAS_W = 24;          // Bias gradient sums

  // Runtime size maxima
  localparam int MAX_T = 16;
  localparam int MAX_L = 4;
  localparam int MAX_X = 4;
  localparam int MAX_R = 4;            // Heads times word width, flattened

  localparam int SIZE_W = 5;           // Size inputs, 0..MAX_T
  localparam int IDX_W  = 2;           // Row and column indices

  // Bank row stride, widest of the column sizes
  localparam int MAX_XR  = (MAX_X > MAX_R) ? MAX_X : MAX_R;
  localparam int MAX_COL = (MAX_XR > MAX_L) ? MAX_XR : MAX_L;

  typedef logic signed [DATA_W-1:0] data_t;
  typedef logic signed [PROD_W-1:0] prod_t;
  typedef logic signed [ACC_W-1:0]  acc_t;
  typedef logic signed [BIAS_W-1:0] bias_t;

endpackage

//--- rtl/step_datapath.sv
// Per-step vector buffers and product stage
// Holds d, x, r, h and the previous h, forms d(row) times the selected
// operand and registers it with its indices for the banks

`timescale 1ns/1ps

module step_datapath
  import ntm_dims_pkg::*;
  import trainer_ctrl_pkg::*;
(
  input  logic             CLK,
  input  logic             RST,
  input  data_t            D_IN,
  input  data_t            X_IN,
  input  data_t            R_IN,
  input  data_t            H_IN,
  input  ldsel_t           load_sel,
  input  logic             load_we,
  input  opsel_t           opsel,
  input  logic             mul_en,
  input  logic             shift_h,
  input  logic [IDX_W-1:0] row,
  input  logic [IDX_W-1:0] col,
  output prod_t            term,
  output logic [IDX_W-1:0] term_row,
  output logic [IDX_W-1:0] term_col,
  output logic             term_valid
);

  data_t d_buf  [MAX_L];
  data_t x_buf  [MAX_X];
  data_t r_buf  [MAX_R];
  data_t h_buf  [MAX_L];
  data_t h_prev [MAX_L];  // h(t-1), valid from t=1
  data_t operand;
  prod_t product;

  //////////////////////////////////////////////////////////////////////
  // Step buffers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (load_we) begin
      case (load_sel)      // Word index comes from the shared counter
        LD_D:    d_buf[col] <= D_IN;
        LD_X:    x_buf[col] <= X_IN;
        LD_R:    r_buf[col] <= R_IN;
        default: h_buf[col] <= H_IN;
      endcase
    end
    if (shift_h) begin
      h_prev <= h_buf;     // Last UPD_B cycle, after dU used the old copy
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Operand select and product register
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (opsel)
      OP_X:     operand = x_buf[col];
      OP_R:     operand = r_buf[col];
      OP_HPREV: operand = h_prev[col];
      default:  operand = '0;  // Unused for bias
    endcase
  end

  // Bias takes d(row) alone, sign-extended
  assign product = (opsel == OP_ONE) ? prod_t'(d_buf[row])
                                     : prod_t'(d_buf[row]) * prod_t'(operand);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      term_valid <= 1'b0;
    end else begin
      term_valid <= mul_en;
    end
  end

  always_ff @(posedge CLK) begin
    if (mul_en) begin
      term     <= product;
      term_row <= row;
      term_col <= col;
    end
  end

endmodule

//--- rtl/trainer_ctrl_pkg.sv
// Controller encodings of the trainer
// State codes of the pass FSM and the select codes it hands to the datapath

package trainer_ctrl_pkg;

  typedef enum logic [3:0] {
    IDLE,
    LOAD_D,     // d(t), L words
    LOAD_X,     // x(t), X words
    LOAD_R,     // r(t), R words
    LOAD_H,     // h(t), L words
    UPD_W,      // L*X terms
    UPD_K,      // L*R terms
    UPD_U,      // L*L terms, skipped at t=0
    UPD_B,      // L terms
    OUT_W,
    OUT_K,
    OUT_U,
    OUT_B,
    FINISH      // Last B word on the ports
  } state_t;

  // Operand multiplied by d(row)
  typedef enum logic [1:0] {OP_X, OP_R, OP_HPREV, OP_ONE} opsel_t;

  // Step buffer written during a load
  typedef enum logic [1:0] {LD_D, LD_X, LD_R, LD_H} ldsel_t;

endpackage

//--- rtl/trainer_fsm.sv
// Pass controller of the gradient stage
// Latches sizes at START, orders load, update and output phases per step,
// and drives counter, datapath, bank strobes and the output framing

`timescale 1ns/1ps

module trainer_fsm
  import ntm_dims_pkg::*;
  import trainer_ctrl_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              START,
  input  logic [SIZE_W-1:0] SIZE_T_IN,
  input  logic [SIZE_W-1:0] SIZE_L_IN,
  input  logic [SIZE_W-1:0] SIZE_X_IN,
  input  logic [SIZE_W-1:0] SIZE_R_IN,
  input  logic              D_IN_ENABLE,
  input  logic              X_IN_ENABLE,
  input  logic              R_IN_ENABLE,
  input  logic              H_IN_ENABLE,
  // Counter
  input  logic [IDX_W-1:0]  row,
  input  logic [IDX_W-1:0]  col,
  input  logic              first_col,
  input  logic              last,
  output logic              cnt_clear,
  output logic              cnt_advance,
  output logic [SIZE_W-1:0] row_limit,
  output logic [SIZE_W-1:0] col_limit,
  // Datapath
  output ldsel_t            load_sel,
  output logic              load_we,
  output opsel_t            opsel,
  output logic              mul_en,
  output logic              shift_h,
  // Banks, bit 0 W, 1 K, 2 U, 3 B
  output logic              bank_clear,
  output logic [3:0]        acc_sel,      // Aligned with term_valid
  output logic [3:0]        rd_en,
  output logic [IDX_W-1:0]  rd_row,
  output logic [IDX_W-1:0]  rd_col,
  // Output framing, one cycle behind the read request
  output logic              W_OUT_L_ENABLE,
  output logic              W_OUT_X_ENABLE,
  output logic              K_OUT_L_ENABLE,
  output logic              K_OUT_K_ENABLE,
  output logic              U_OUT_L_ENABLE,
  output logic              U_OUT_P_ENABLE,
  output logic              B_OUT_ENABLE,
  output logic              READY
);

  state_t            state;
  state_t            state_nxt;
  logic [SIZE_W-1:0] t_len, l_len, x_len, r_len;  // Latched sizes
  logic [SIZE_W-1:0] step;                        // Current t
  logic              phase_done;
  logic              final_step;

  assign phase_done = cnt_advance & last;
  assign final_step = (step == t_len - SIZE_W'(1));

  assign cnt_clear   = (state == IDLE);
  assign bank_clear  = (state == IDLE) & START;
  assign shift_h     = (state == UPD_B) & last;   // h -> h_prev at end of step
  assign rd_en       = {state == OUT_B, state == OUT_U, state == OUT_K, state == OUT_W};
  assign rd_row      = row;
  assign rd_col      = col;
  assign cnt_advance = load_we | mul_en | (|rd_en);

  //////////////////////////////////////////////////////////////////////
  // Phase decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    load_sel  = LD_D;
    load_we   = 1'b0;
    opsel     = OP_ONE;
    mul_en    = 1'b0;
    row_limit = SIZE_W'(1);  // Loads walk a single row
    col_limit = l_len;
    case (state)
      LOAD_D: load_we = D_IN_ENABLE;
      LOAD_X: begin
        load_sel  = LD_X;
        load_we   = X_IN_ENABLE;
        col_limit = x_len;
      end
      LOAD_R: begin
        load_sel  = LD_R;
        load_we   = R_IN_ENABLE;
        col_limit = r_len;
      end
      LOAD_H: begin
        load_sel = LD_H;
        load_we  = H_IN_ENABLE;
      end
      UPD_W, OUT_W: begin
        row_limit = l_len;
        col_limit = x_len;
        opsel     = OP_X;
        mul_en    = (state == UPD_W);
      end
      UPD_K, OUT_K: begin
        row_limit = l_len;
        col_limit = r_len;
        opsel     = OP_R;
        mul_en    = (state == UPD_K);
      end
      UPD_U, OUT_U: begin
        row_limit = l_len;
        opsel     = OP_HPREV;
        mul_en    = (state == UPD_U);
      end
      UPD_B, OUT_B: begin
        row_limit = l_len;
        col_limit = SIZE_W'(1);
        mul_en    = (state == UPD_B);  // d passes straight through
      end
      default: ;
    endcase
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:   if (START) state_nxt = LOAD_D;
      LOAD_D: if (phase_done) state_nxt = LOAD_X;
      LOAD_X: if (phase_done) state_nxt = LOAD_R;
      LOAD_R: if (phase_done) state_nxt = LOAD_H;
      LOAD_H: if (phase_done) state_nxt = UPD_W;
      UPD_W:  if (phase_done) state_nxt = UPD_K;
      UPD_K:  if (phase_done) state_nxt = (step == '0) ? UPD_B : UPD_U;  // No h(-1)
      UPD_U:  if (phase_done) state_nxt = UPD_B;
      UPD_B:  if (phase_done) state_nxt = final_step ? OUT_W : LOAD_D;
      OUT_W:  if (phase_done) state_nxt = OUT_K;
      OUT_K:  if (phase_done) state_nxt = OUT_U;
      OUT_U:  if (phase_done) state_nxt = OUT_B;
      OUT_B:  if (phase_done) state_nxt = FINISH;
      default: state_nxt = IDLE;  // FINISH included
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // State, sizes and step count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= IDLE;
      step  <= '0;
      t_len <= '0;
      l_len <= '0;
      x_len <= '0;
      r_len <= '0;
    end else begin
      state <= state_nxt;
      if (bank_clear) begin  // START seen in IDLE
        t_len <= SIZE_T_IN;
        l_len <= SIZE_L_IN;
        x_len <= SIZE_X_IN;
        r_len <= SIZE_R_IN;
        step  <= '0;
      end else if (shift_h && !final_step) begin
        step <= step + 1'b1;
      end
    end
  end

  // Bank select and framing, one cycle late
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc_sel        <= '0;
      W_OUT_L_ENABLE <= 1'b0;
      W_OUT_X_ENABLE <= 1'b0;
      K_OUT_L_ENABLE <= 1'b0;
      K_OUT_K_ENABLE <= 1'b0;
      U_OUT_L_ENABLE <= 1'b0;
      U_OUT_P_ENABLE <= 1'b0;
      B_OUT_ENABLE   <= 1'b0;
      READY          <= 1'b0;
    end else begin
      acc_sel        <= {state == UPD_B, state == UPD_U, state == UPD_K, state == UPD_W};
      W_OUT_X_ENABLE <= rd_en[0];
      W_OUT_L_ENABLE <= rd_en[0] & first_col;  // Row start
      K_OUT_K_ENABLE <= rd_en[1];
      K_OUT_L_ENABLE <= rd_en[1] & first_col;
      U_OUT_P_ENABLE <= rd_en[2];
      U_OUT_L_ENABLE <= rd_en[2] & first_col;
      B_OUT_ENABLE   <= rd_en[3];
      READY          <= (state == FINISH);     // Cycle after last B word
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Builds the gradient-stage testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_accelerator_trainer \
  -f tb.f -o tb_sim

if ./obj_dir/tb_sim | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- tb.f
rtl/ntm_dims_pkg.sv
rtl/trainer_ctrl_pkg.sv
rtl/index_counter.sv
rtl/trainer_fsm.sv
rtl/step_datapath.sv
rtl/gradient_bank.sv
rtl/accelerator_trainer.sv
tests/trainer_sva.sv
tests/tb_accelerator_trainer.sv

//--- tests/tb_accelerator_trainer.sv
// Table-driven testbench of the gradient stage
// Each table row runs one pass with random d, x, r, h vectors, rebuilds
// dW, dK, dU and db in a model and checks the streams and the READY pulse

`timescale 1ns/1ps

module tb_accelerator_trainer
  import ntm_dims_pkg::*;
();

  localparam int PERIOD = 10;
  localparam int NCASES = 6;
  localparam int SEED   = 24409;

  typedef struct {
    int t;
    int l;
    int x;
    int r;
    int gap;    // Percent chance of idle cycles before a word
    int words;  // All four streams together
  } case_t;

  case_t cases [NCASES];

  logic              CLK;
  logic              RST;
  logic              start;
  logic [SIZE_W-1:0] t_size;
  logic [SIZE_W-1:0] l_size;
  logic [SIZE_W-1:0] x_size;
  logic [SIZE_W-1:0] r_size;
  data_t             d_in;
  data_t             x_in;
  data_t             r_in;
  data_t             h_in;
  logic              d_en;
  logic              x_en;
  logic              r_en;
  logic              h_en;
  acc_t              w_out;
  acc_t              k_out;
  acc_t              u_out;
  bias_t             b_out;
  logic              w_l_en;
  logic              w_x_en;
  logic              k_l_en;
  logic              k_k_en;
  logic              u_l_en;
  logic              u_p_en;
  logic              b_en;
  logic              ready;

  // Step vectors of the running pass
  data_t dv [MAX_T][MAX_L];
  data_t xv [MAX_T][MAX_X];
  data_t rv [MAX_T][MAX_R];
  data_t hv [MAX_T][MAX_L];

  // Collector state owned by the negedge monitor
  longint w_q [$];
  longint k_q [$];
  longint u_q [$];
  longint b_q [$];
  int     last_stream = 0;
  int     ready_cnt   = 0;
  logic   prev_b      = 1'b0;
  int     mon_errors  = 0;
  int     mon_checks  = 0;

  logic armed  = 1'b0;  // High while a pass may drive outputs
  int   cur_l  = 1;
  int   cur_x  = 1;
  int   cur_r  = 1;
  int   errors = 0;
  int   checks = 0;

  accelerator_trainer u_accelerator_trainer (
    .CLK            (CLK),
    .RST            (RST),
    .START          (start),
    .READY          (ready),
    .SIZE_T_IN      (t_size),
    .SIZE_L_IN      (l_size),
    .SIZE_X_IN      (x_size),
    .SIZE_R_IN      (r_size),
    .D_IN           (d_in),
    .D_IN_ENABLE    (d_en),
    .X_IN           (x_in),
    .X_IN_ENABLE    (x_en),
    .R_IN           (r_in),
    .R_IN_ENABLE    (r_en),
    .H_IN           (h_in),
    .H_IN_ENABLE    (h_en),
    .W_OUT          (w_out),
    .W_OUT_L_ENABLE (w_l_en),
    .W_OUT_X_ENABLE (w_x_en),
    .K_OUT          (k_out),
    .K_OUT_L_ENABLE (k_l_en),
    .K_OUT_K_ENABLE (k_k_en),
    .U_OUT          (u_out),
    .U_OUT_L_ENABLE (u_l_en),
    .U_OUT_P_ENABLE (u_p_en),
    .B_OUT          (b_out),
    .B_OUT_ENABLE   (b_en)
  );

  always #(PERIOD / 2) CLK = ~CLK;

  //////////////////////////////////////////////////////////////////////
  // Stimulus table and helpers
  //////////////////////////////////////////////////////////////////////

  function automatic void load_table();
    //           T   L  X  R  gap words
    cases[0] = '{ 1, 2, 3, 2,  0, 16};  // Single step with dU all zero
    cases[1] = '{16, 4, 4, 4, 25, 52};  // Full maxima
    cases[2] = '{ 1, 1, 1, 1, 50,  4};  // Minimal sizes
    cases[3] = '{ 3, 3, 2, 3, 30, 27};
    cases[4] = '{ 5, 2, 4, 1, 10, 16};
    cases[5] = '{ 2, 1, 1, 1,  0,  4};  // Shortest dU chain
  endfunction

  // At most 3 idle cycles per word
  function automatic int worst_cycles(input int i);
    int l;
    int step_words;
    int step_upd;
    l          = cases[i].l;
    step_words = 2 * l + cases[i].x + cases[i].r;
    step_upd   = l * cases[i].x + l * cases[i].r + l * l + l;
    return cases[i].t * (4 * step_words + step_upd) + cases[i].words + 30;
  endfunction

  function automatic data_t rand_word();
    return data_t'($urandom);
  endfunction

  function automatic int cols_of(input int kind);
    case (kind)
      0:       return cur_x;
      1:       return cur_r;
      2:       return cur_l;
      default: return 1;    // Bias has one word per row
    endcase
  endfunction

  function automatic string stream_name(input int kind);
    case (kind)
      0:       return "W_OUT";
      1:       return "K_OUT";
      2:       return "U_OUT";
      default: return "B_OUT";
    endcase
  endfunction

  function automatic int stream_size(input int kind);
    case (kind)
      0:       return w_q.size();
      1:       return k_q.size();
      2:       return u_q.size();
      default: return b_q.size();
    endcase
  endfunction

  function automatic longint stream_word(input int kind, input int idx);
    case (kind)
      0:       return w_q[idx];
      1:       return k_q[idx];
      2:       return u_q[idx];
      default: return b_q[idx];
    endcase
  endfunction

  // Gradient sums straight from the stored vectors
  function automatic longint model_sum(input int kind, input int t_len, input int l,
                                       input int c);
    longint s;
    longint d;
    s = 0;
    for (int t = 0; t < t_len; t++) begin
      d = longint'(dv[t][l]);
      case (kind)
        0: s += d * longint'(xv[t][c]);
        1: s += d * longint'(rv[t][c]);
        2: if (t > 0) s += d * longint'(hv[t-1][c]);  // No h(t-1) at t=0
        default: s += d;
      endcase
    end
    return s;
  endfunction

  function automatic void set_port(input int port, input data_t data, input logic en);
    case (port)
      0: begin
        d_in = data;
        d_en = en;
      end
      1: begin
        x_in = data;
        x_en = en;
      end
      2: begin
        r_in = data;
        r_en = en;
      end
      default: begin
        h_in = data;
        h_en = en;
      end
    endcase
  endfunction

  function automatic void clear_enables();
    d_en = 1'b0;
    x_en = 1'b0;
    r_en = 1'b0;
    h_en = 1'b0;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Output collector
  //////////////////////////////////////////////////////////////////////

  function automatic void take_order(input int kind);
    if (kind < last_stream) begin
      $display("%s words arrived after a later stream", stream_name(kind));
      mon_errors++;
    end
    last_stream = kind;
  endfunction

  function automatic void check_row_flag(input int kind, input logic flag, input int idx);
    logic exp_flag;
    exp_flag = (idx % cols_of(kind) == 0);  // Column 0 opens a row
    mon_checks++;
    if (flag !== exp_flag) begin
      $display("[FAIL] %s_L_ENABLE at word %0d: got %h expected %h",
               stream_name(kind), idx, flag, exp_flag);
      mon_errors++;
    end
  endfunction

  // Sampled mid-cycle once the outputs have settled
  always @(negedge CLK) begin
    if (!RST) begin
      if (start) begin  // Fresh pass
        w_q.delete();
        k_q.delete();
        u_q.delete();
        b_q.delete();
        last_stream = 0;
        ready_cnt   = 0;
      end
      if (!armed && (w_x_en || w_l_en || k_k_en || k_l_en || u_p_en || u_l_en ||
                     b_en || ready)) begin
        $display("Output enable or READY high with no pass running at %0t", $time);
        mon_errors++;
      end
      if (w_x_en) begin
        take_order(0);
        check_row_flag(0, w_l_en, w_q.size());
        w_q.push_back(longint'(w_out));
      end
      if (k_k_en) begin
        take_order(1);
        check_row_flag(1, k_l_en, k_q.size());
        k_q.push_back(longint'(k_out));
      end
      if (u_p_en) begin
        take_order(2);
        check_row_flag(2, u_l_en, u_q.size());
        u_q.push_back(longint'(u_out));
      end
      if (b_en) begin
        take_order(3);
        b_q.push_back(longint'(b_out));
      end
      if (ready) begin
        ready_cnt++;
        mon_checks++;
        if (!prev_b || b_q.size() != cur_l) begin
          $display("READY did not follow the last B_OUT word (%0d of %0d words)",
                   b_q.size(), cur_l);
          mon_errors++;
        end
      end
      prev_b = b_en;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pass driver and result check
  //////////////////////////////////////////////////////////////////////

  // Idle cycles carry a strobe on some other port that the DUT must ignore
  task automatic send_word(input int port, input data_t data, input int gap);
    int idle;
    int decoy;
    idle = 0;
    if (int'($urandom_range(99)) < gap) begin
      idle = int'($urandom_range(3, 1));
    end
    repeat (idle) begin
      decoy = (port + 1 + int'($urandom_range(2))) % 4;
      set_port(decoy, rand_word(), 1'b1);
      @(posedge CLK);
      #1;
      clear_enables();
    end
    set_port(port, data, 1'b1);
    @(posedge CLK);
    #1;
    clear_enables();
  endtask

  function automatic void check_results(input int i);
    int     cols;
    int     idx;
    int     total;
    longint got;
    longint exp;
    total = 0;
    for (int kind = 0; kind < 4; kind++) begin
      cols  = cols_of(kind);
      total += stream_size(kind);
      checks++;
      if (stream_size(kind) != cur_l * cols) begin
        $display("[FAIL] case %0d %s word count: got %h expected %h",
                 i, stream_name(kind), stream_size(kind), cur_l * cols);
        errors++;
      end
      for (int l = 0; l < cur_l; l++) begin
        for (int c = 0; c < cols; c++) begin
          idx = l * cols + c;  // Row-major
          if (idx < stream_size(kind)) begin
            got = stream_word(kind, idx);
            exp = model_sum(kind, cases[i].t, l, c);
            checks++;
            if (got != exp) begin
              $display("[FAIL] case %0d %s[%0d][%0d]: got %h expected %h",
                       i, stream_name(kind), l, c, got, exp);
              errors++;
            end
          end
        end
      end
    end
    checks++;
    if (total != cases[i].words) begin
      $display("[FAIL] case %0d total words: got %h expected %h", i, total, cases[i].words);
      errors++;
    end
    checks++;
    if (ready_cnt != 1) begin
      $display("Case %0d: READY pulsed %0d times instead of once", i, ready_cnt);
      errors++;
    end
  endfunction

  task automatic run_pass(input int i);
    int upd;
    int wait_cyc;
    cur_l = cases[i].l;
    cur_x = cases[i].x;
    cur_r = cases[i].r;
    for (int t = 0; t < cases[i].t; t++) begin
      for (int j = 0; j < MAX_L; j++) begin
        dv[t][j] = rand_word();
        hv[t][j] = rand_word();
      end
      for (int j = 0; j < MAX_X; j++) begin
        xv[t][j] = rand_word();
      end
      for (int j = 0; j < MAX_R; j++) begin
        rv[t][j] = rand_word();
      end
    end
    t_size = SIZE_W'(cases[i].t);
    l_size = SIZE_W'(cur_l);
    x_size = SIZE_W'(cur_x);
    r_size = SIZE_W'(cur_r);
    armed  = 1'b1;
    start  = 1'b1;
    @(posedge CLK);  // FSM leaves IDLE and clears the banks
    #1;
    start = 1'b0;
    for (int t = 0; t < cases[i].t; t++) begin
      for (int j = 0; j < cur_l; j++) send_word(0, dv[t][j], cases[i].gap);
      for (int j = 0; j < cur_x; j++) send_word(1, xv[t][j], cases[i].gap);
      for (int j = 0; j < cur_r; j++) send_word(2, rv[t][j], cases[i].gap);
      for (int j = 0; j < cur_l; j++) send_word(3, hv[t][j], cases[i].gap);
      // Update phases have a fixed length with dU only from the second step
      upd = cur_l * cur_x + cur_l * cur_r + cur_l + ((t > 0) ? cur_l * cur_l : 0);
      repeat (upd) @(posedge CLK);
      #1;
    end
    wait_cyc = 0;
    while (ready_cnt == 0 && wait_cyc < cases[i].words + 20) begin
      @(posedge CLK);
      wait_cyc++;
    end
    checks++;
    if (ready_cnt == 0) begin
      $display("Case %0d: READY never came after the output streams", i);
      errors++;
    end
    repeat (3) @(posedge CLK);  // Window for a stray second READY
    #1;
    armed = 1'b0;
    check_results(i);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    CLK    = 1'b0;
    RST    = 1'b1;
    start  = 1'b0;
    t_size = '0;
    l_size = '0;
    x_size = '0;
    r_size = '0;
    d_in   = '0;
    x_in   = '0;
    r_in   = '0;
    h_in   = '0;
    clear_enables();
    load_table();
    repeat (3) @(posedge CLK);
    #1;
    RST = 1'b0;
    repeat (5) @(posedge CLK);  // Quiet window after reset with nothing armed
    #1;
    for (int i = 0; i < NCASES; i++) begin
      run_pass(i);  // Back-to-back passes that each start from cleared banks
    end
    $display("Summary: %0d checks, %0d errors", checks + mon_checks, errors + mon_errors);
    if (errors + mon_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Three times the worst case of the whole table
  initial begin
    int limit;
    @(negedge RST);
    limit = 0;
    for (int i = 0; i < NCASES; i++) begin
      limit += worst_cycles(i);
    end
    limit = 3 * limit + 100;
    repeat (limit) @(posedge CLK);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("Summary: %0d checks, %0d errors", checks + mon_checks,
             errors + mon_errors + 1);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- tests/trainer_sva.sv
// Concurrent checks on the trainer's output framing and READY pulse
// Bound into every accelerator_trainer by the bind at the end of this file

`timescale 1ns/1ps

module trainer_sva (
  input logic CLK,
  input logic RST,
  input logic START,
  input logic READY,
  input logic W_OUT_L_ENABLE,
  input logic W_OUT_X_ENABLE,
  input logic K_OUT_L_ENABLE,
  input logic K_OUT_K_ENABLE,
  input logic U_OUT_L_ENABLE,
  input logic U_OUT_P_ENABLE,
  input logic B_OUT_ENABLE
);

  logic [3:0] col_en;  // One bit per output stream
  logic       any_en;

  assign col_en = {B_OUT_ENABLE, U_OUT_P_ENABLE, K_OUT_K_ENABLE, W_OUT_X_ENABLE};
  assign any_en = (|col_en) | W_OUT_L_ENABLE | K_OUT_L_ENABLE | U_OUT_L_ENABLE;

  // Single-cycle done pulse
  ready_pulse: assert property (@(posedge CLK) disable iff (RST) READY |=> !READY)
    else $error("READY stayed high for two cycles");

  // Row start only on a valid word
  row_with_col: assert property (@(posedge CLK) disable iff (RST)
    (W_OUT_L_ENABLE -> W_OUT_X_ENABLE) &&
    (K_OUT_L_ENABLE -> K_OUT_K_ENABLE) &&
    (U_OUT_L_ENABLE -> U_OUT_P_ENABLE))
    else $error("Row enable without its column enable");

  one_stream: assert property (@(posedge CLK) disable iff (RST) $onehot0(col_en))
    else $error("Two output streams active in one cycle");

  // START cycle and the one after stay quiet
  quiet_at_start: assert property (@(posedge CLK) disable iff (RST)
    (START || $past(START)) |-> !any_en)
    else $error("Output enable high within one cycle of START");

endmodule

bind accelerator_trainer trainer_sva u_sva (
  .CLK            (CLK),
  .RST            (RST),
  .START          (START),
  .READY          (READY),
  .W_OUT_L_ENABLE (W_OUT_L_ENABLE),
  .W_OUT_X_ENABLE (W_OUT_X_ENABLE),
  .K_OUT_L_ENABLE (K_OUT_L_ENABLE),
  .K_OUT_K_ENABLE (K_OUT_K_ENABLE),
  .U_OUT_L_ENABLE (U_OUT_L_ENABLE),
  .U_OUT_P_ENABLE (U_OUT_P_ENABLE),
  .B_OUT_ENABLE   (B_OUT_ENABLE)
);
